// ==== verilog/router_pkg.sv ====
/* Router shared types */

`default_nettype none

package router_pkg;

    ////////////////////////////////////////
    // Sizing

    // Single stream width for every port
    localparam int DATA_BYTES = 4;

    // Sizes the source tag
    localparam int MAX_PORTS = 8;

    localparam int CNT_WIDTH = 16;

    ////////////////////////////////////////
    // Types

    typedef logic [DATA_BYTES*8-1:0] word_t;

    typedef logic [DATA_BYTES-1:0] keep_t;

    // Saturating packet count
    typedef logic [CNT_WIDTH-1:0] cnt_t;

    typedef logic [$clog2(MAX_PORTS)-1:0] port_idx_t;

    typedef enum logic {
        ARB_IDLE   = 1'b0,
        ARB_PACKET = 1'b1
    } arb_state_t;

endpackage

`default_nettype wire

// ==== verilog/port_fifo.sv ====
/* Port ingress buffer */

`default_nettype none

module port_fifo #(
    parameter int NUM_PORTS  = 4,
    parameter int FIFO_DEPTH = 16
) (
    input  logic              phys_port_clk_ifc,
    input  logic              rst,
    input  logic              enable,
    input  router_pkg::word_t ing_tdata,
    input  router_pkg::keep_t ing_tkeep,
    input  logic              ing_tlast,
    input  logic              ing_tvalid,
    output logic              ing_tready,
    output router_pkg::word_t buf_tdata,
    output router_pkg::keep_t buf_tkeep,
    output logic              buf_tlast,
    output logic              buf_tvalid,
    input  logic              buf_tready,
    output logic              pkt_in
);

    import router_pkg::*;

    localparam int AW = $clog2(FIFO_DEPTH);

    word_t         mem_data [FIFO_DEPTH];
    keep_t         mem_keep [FIFO_DEPTH];
    logic          mem_last [FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          wr_en;
    logic          rd_en;

    if (NUM_PORTS < 2 || NUM_PORTS > MAX_PORTS) begin : g_bad_port_count
        $error("port_fifo: NUM_PORTS outside 2..MAX_PORTS");
    end

    // Disabled port sinks everything
    assign ing_tready = !enable || (count != (AW+1)'(FIFO_DEPTH));
    assign wr_en      = ing_tvalid && ing_tready && enable;
    assign rd_en      = buf_tvalid && buf_tready;

    // First word falls through
    assign buf_tvalid = (count != '0);
    assign buf_tdata  = mem_data[rd_ptr];
    assign buf_tkeep  = mem_keep[rd_ptr];
    assign buf_tlast  = mem_last[rd_ptr];

    always_ff @(posedge phys_port_clk_ifc) begin
        if (wr_en) begin
            mem_data[wr_ptr] <= ing_tdata;
            mem_keep[wr_ptr] <= ing_tkeep;
            mem_last[wr_ptr] <= ing_tlast;
        end
    end

    always_ff @(posedge phys_port_clk_ifc) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            pkt_in <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
            // Stored packet end
            pkt_in <= wr_en && ing_tlast;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/ingress_arbiter.sv ====
/* Packet round-robin arbiter */

`default_nettype none

module ingress_arbiter #(
    parameter int NUM_PORTS = 4
) (
    input  logic                                phys_port_clk_ifc,
    input  logic                                rst,
    input  router_pkg::word_t [NUM_PORTS-1:0]   buf_tdata,
    input  router_pkg::keep_t [NUM_PORTS-1:0]   buf_tkeep,
    input  logic [NUM_PORTS-1:0]                buf_tlast,
    input  logic [NUM_PORTS-1:0]                buf_tvalid,
    output logic [NUM_PORTS-1:0]                buf_tready,
    output router_pkg::word_t                   core_tdata,
    output router_pkg::keep_t                   core_tkeep,
    output logic                                core_tlast,
    output logic                                core_tvalid,
    input  logic                                core_tready,
    output router_pkg::port_idx_t               core_src
);

    import router_pkg::*;

    localparam int IDX_W = $clog2(NUM_PORTS);

    arb_state_t       state;
    logic [IDX_W-1:0] grant;
    logic [IDX_W-1:0] rr_ptr;
    logic [IDX_W-1:0] pick;
    logic             pick_valid;

    ////////////////////////////////////////
    // Next requester at or after rr_ptr

    always_comb begin
        int idx;
        pick       = rr_ptr;
        pick_valid = 1'b0;
        for (int off = 0; off < NUM_PORTS; off++) begin
            idx = (int'(rr_ptr) + off) % NUM_PORTS;
            if (!pick_valid && buf_tvalid[idx]) begin
                pick       = IDX_W'(idx);
                pick_valid = 1'b1;
            end
        end
    end

    always_ff @(posedge phys_port_clk_ifc) begin
        if (rst) begin
            state  <= ARB_IDLE;
            grant  <= '0;
            rr_ptr <= '0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (pick_valid) begin
                        state  <= ARB_PACKET;
                        grant  <= pick;
                        rr_ptr <= (pick == IDX_W'(NUM_PORTS-1)) ? '0 : pick + 1'b1;
                    end
                end
                ARB_PACKET: begin
                    // Hold grant until the packet end moves
                    if (core_tvalid && core_tready && core_tlast) begin
                        state <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////
    // Granted buffer straight through

    assign core_tvalid = (state == ARB_PACKET) && buf_tvalid[grant];
    assign core_tdata  = buf_tdata[grant];
    assign core_tkeep  = buf_tkeep[grant];
    assign core_tlast  = buf_tlast[grant];
    assign core_src    = port_idx_t'(grant);

    always_comb begin
        buf_tready = '0;
        if (state == ARB_PACKET) begin
            buf_tready[grant] = core_tready;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/egress_demux.sv ====
/* Egress port demux */

`default_nettype none

module egress_demux #(
    parameter int NUM_PORTS = 4
) (
    input  logic                                phys_port_clk_ifc,
    input  logic                                rst,
    input  router_pkg::word_t                   core_tdata,
    input  router_pkg::keep_t                   core_tkeep,
    input  logic                                core_tlast,
    input  logic                                core_tvalid,
    input  router_pkg::port_idx_t               core_src,
    output logic                                core_tready,
    output router_pkg::word_t [NUM_PORTS-1:0]   egr_tdata,
    output router_pkg::keep_t [NUM_PORTS-1:0]   egr_tkeep,
    output logic [NUM_PORTS-1:0]                egr_tlast,
    output logic [NUM_PORTS-1:0]                egr_tvalid,
    input  logic [NUM_PORTS-1:0]                egr_tready,
    output logic [NUM_PORTS-1:0]                pkt_out
);

    import router_pkg::*;

    localparam int IDX_W = $clog2(NUM_PORTS);

    logic [IDX_W-1:0]     sel;
    logic [NUM_PORTS-1:0] load;

    // Slot free or draining this cycle
    assign sel         = core_src[IDX_W-1:0];
    assign core_tready = !egr_tvalid[sel] || egr_tready[sel];

    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            load[i] = core_tvalid && core_tready && (core_src == port_idx_t'(i));
        end
    end

    always_ff @(posedge phys_port_clk_ifc) begin
        if (rst) begin
            egr_tvalid <= '0;
        end else begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                if (load[i]) begin
                    egr_tvalid[i] <= 1'b1;
                end else if (egr_tready[i]) begin
                    egr_tvalid[i] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge phys_port_clk_ifc) begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (load[i]) begin
                egr_tdata[i] <= core_tdata;
                egr_tkeep[i] <= core_tkeep;
                egr_tlast[i] <= core_tlast;
            end
        end
    end

    assign pkt_out = egr_tvalid & egr_tready & egr_tlast;

endmodule

`default_nettype wire

// ==== verilog/packet_counters.sv ====
/* Port packet counters */

`default_nettype none

module packet_counters #(
    parameter int NUM_PORTS = 4
) (
    input  logic                              phys_port_clk_ifc,
    input  logic                              rst,
    input  logic [NUM_PORTS-1:0]              pkt_in,
    input  logic [NUM_PORTS-1:0]              pkt_out,
    input  logic [NUM_PORTS-1:0]              cnt_clear,
    output router_pkg::cnt_t [NUM_PORTS-1:0]  ing_pkt_cnt,
    output router_pkg::cnt_t [NUM_PORTS-1:0]  egr_pkt_cnt
);

    ////////////////////////////////////////
    // Saturating counts, clear first

    always_ff @(posedge phys_port_clk_ifc) begin
        if (rst) begin
            ing_pkt_cnt <= '0;
            egr_pkt_cnt <= '0;
        end else begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                if (cnt_clear[i]) begin
                    ing_pkt_cnt[i] <= '0;
                    egr_pkt_cnt[i] <= '0;
                end else begin
                    if (pkt_in[i] && (ing_pkt_cnt[i] != '1)) begin
                        ing_pkt_cnt[i] <= ing_pkt_cnt[i] + 1'b1;
                    end
                    if (pkt_out[i] && (egr_pkt_cnt[i] != '1)) begin
                        egr_pkt_cnt[i] <= egr_pkt_cnt[i] + 1'b1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/router_top.sv ====
/* Packet router top */

`default_nettype none

module router_top #(
    parameter int NUM_PORTS  = 4,
    parameter int FIFO_DEPTH = 16
) (
    input  logic                                phys_port_clk_ifc,
    input  logic                                rst,
    input  router_pkg::word_t [NUM_PORTS-1:0]   ing_tdata,
    input  router_pkg::keep_t [NUM_PORTS-1:0]   ing_tkeep,
    input  logic [NUM_PORTS-1:0]                ing_tlast,
    input  logic [NUM_PORTS-1:0]                ing_tvalid,
    output logic [NUM_PORTS-1:0]                ing_tready,
    output router_pkg::word_t [NUM_PORTS-1:0]   egr_tdata,
    output router_pkg::keep_t [NUM_PORTS-1:0]   egr_tkeep,
    output logic [NUM_PORTS-1:0]                egr_tlast,
    output logic [NUM_PORTS-1:0]                egr_tvalid,
    input  logic [NUM_PORTS-1:0]                egr_tready,
    input  logic [NUM_PORTS-1:0]                port_enable,
    input  logic [NUM_PORTS-1:0]                cnt_clear,
    output router_pkg::cnt_t [NUM_PORTS-1:0]    ing_pkt_cnt,
    output router_pkg::cnt_t [NUM_PORTS-1:0]    egr_pkt_cnt
);

    import router_pkg::*;

    word_t [NUM_PORTS-1:0] buf_tdata;
    keep_t [NUM_PORTS-1:0] buf_tkeep;
    logic  [NUM_PORTS-1:0] buf_tlast;
    logic  [NUM_PORTS-1:0] buf_tvalid;
    logic  [NUM_PORTS-1:0] buf_tready;
    logic  [NUM_PORTS-1:0] pkt_in;
    logic  [NUM_PORTS-1:0] pkt_out;
    word_t                 core_tdata;
    keep_t                 core_tkeep;
    logic                  core_tlast;
    logic                  core_tvalid;
    logic                  core_tready;
    port_idx_t             core_src;

    ////////////////////////////////////////
    // Ingress buffers

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
        port_fifo #(
            .NUM_PORTS  ( NUM_PORTS  ),
            .FIFO_DEPTH ( FIFO_DEPTH )
        ) u_port_fifo (
            .phys_port_clk_ifc ( phys_port_clk_ifc ),
            .rst               ( rst               ),
            .enable            ( port_enable[i]    ),
            .ing_tdata         ( ing_tdata[i]      ),
            .ing_tkeep         ( ing_tkeep[i]      ),
            .ing_tlast         ( ing_tlast[i]      ),
            .ing_tvalid        ( ing_tvalid[i]     ),
            .ing_tready        ( ing_tready[i]     ),
            .buf_tdata         ( buf_tdata[i]      ),
            .buf_tkeep         ( buf_tkeep[i]      ),
            .buf_tlast         ( buf_tlast[i]      ),
            .buf_tvalid        ( buf_tvalid[i]     ),
            .buf_tready        ( buf_tready[i]     ),
            .pkt_in            ( pkt_in[i]         )
        );
    end

    ////////////////////////////////////////
    // Core stream

    ingress_arbiter #(
        .NUM_PORTS ( NUM_PORTS )
    ) u_ingress_arbiter (
        .phys_port_clk_ifc ( phys_port_clk_ifc ),
        .rst               ( rst               ),
        .buf_tdata         ( buf_tdata         ),
        .buf_tkeep         ( buf_tkeep         ),
        .buf_tlast         ( buf_tlast         ),
        .buf_tvalid        ( buf_tvalid        ),
        .buf_tready        ( buf_tready        ),
        .core_tdata        ( core_tdata        ),
        .core_tkeep        ( core_tkeep        ),
        .core_tlast        ( core_tlast        ),
        .core_tvalid       ( core_tvalid       ),
        .core_tready       ( core_tready       ),
        .core_src          ( core_src          )
    );

    // Echo rule, source tag picks the egress port
    egress_demux #(
        .NUM_PORTS ( NUM_PORTS )
    ) u_egress_demux (
        .phys_port_clk_ifc ( phys_port_clk_ifc ),
        .rst               ( rst               ),
        .core_tdata        ( core_tdata        ),
        .core_tkeep        ( core_tkeep        ),
        .core_tlast        ( core_tlast        ),
        .core_tvalid       ( core_tvalid       ),
        .core_src          ( core_src          ),
        .core_tready       ( core_tready       ),
        .egr_tdata         ( egr_tdata         ),
        .egr_tkeep         ( egr_tkeep         ),
        .egr_tlast         ( egr_tlast         ),
        .egr_tvalid        ( egr_tvalid        ),
        .egr_tready        ( egr_tready        ),
        .pkt_out           ( pkt_out           )
    );

    packet_counters #(
        .NUM_PORTS ( NUM_PORTS )
    ) u_packet_counters (
        .phys_port_clk_ifc ( phys_port_clk_ifc ),
        .rst               ( rst               ),
        .pkt_in            ( pkt_in            ),
        .pkt_out           ( pkt_out           ),
        .cnt_clear         ( cnt_clear         ),
        .ing_pkt_cnt       ( ing_pkt_cnt       ),
        .egr_pkt_cnt       ( egr_pkt_cnt       )
    );

endmodule

`default_nettype wire

// ==== bench/router_tb.sv ====
/* Router testbench */

`default_nettype none

module router_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import router_pkg::*;

    localparam int NUM_PORTS  = 4;
    localparam int WAIT_LIMIT = 2000;

    logic                  phys_port_clk_ifc;
    logic                  rst;
    word_t [NUM_PORTS-1:0] ing_tdata;
    keep_t [NUM_PORTS-1:0] ing_tkeep;
    logic  [NUM_PORTS-1:0] ing_tlast;
    logic  [NUM_PORTS-1:0] ing_tvalid;
    logic  [NUM_PORTS-1:0] ing_tready;
    word_t [NUM_PORTS-1:0] egr_tdata;
    keep_t [NUM_PORTS-1:0] egr_tkeep;
    logic  [NUM_PORTS-1:0] egr_tlast;
    logic  [NUM_PORTS-1:0] egr_tvalid;
    logic  [NUM_PORTS-1:0] egr_tready;
    logic  [NUM_PORTS-1:0] port_enable;
    logic  [NUM_PORTS-1:0] cnt_clear;
    cnt_t  [NUM_PORTS-1:0] ing_pkt_cnt;
    cnt_t  [NUM_PORTS-1:0] egr_pkt_cnt;

    // Expected words per egress port as {data, keep, last}
    logic [36:0] exp_q [NUM_PORTS][$];
    int          sent_pkts [NUM_PORTS];
    int          rx_pkts [NUM_PORTS];
    logic        random_ready;

    router_top #(
        .NUM_PORTS  ( NUM_PORTS ),
        .FIFO_DEPTH ( 16        )
    ) u_router_top (
        .phys_port_clk_ifc ( phys_port_clk_ifc ),
        .rst               ( rst               ),
        .ing_tdata         ( ing_tdata         ),
        .ing_tkeep         ( ing_tkeep         ),
        .ing_tlast         ( ing_tlast         ),
        .ing_tvalid        ( ing_tvalid        ),
        .ing_tready        ( ing_tready        ),
        .egr_tdata         ( egr_tdata         ),
        .egr_tkeep         ( egr_tkeep         ),
        .egr_tlast         ( egr_tlast         ),
        .egr_tvalid        ( egr_tvalid        ),
        .egr_tready        ( egr_tready        ),
        .port_enable       ( port_enable       ),
        .cnt_clear         ( cnt_clear         ),
        .ing_pkt_cnt       ( ing_pkt_cnt       ),
        .egr_pkt_cnt       ( egr_pkt_cnt       )
    );

    initial begin
        phys_port_clk_ifc = 1'b0;
        forever #5 phys_port_clk_ifc = ~phys_port_clk_ifc;
    end

    ////////////////////////////////////////
    // Failure handling

    task automatic stop_on_failure(input string why);
        $display("=== FAIL ===");
        $fatal(1, "%s", why);
    endtask

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            $display("error %0t: %s got %0h expected %0h", $time, what, got, expected);
            stop_on_failure("value mismatch");
        end
    endtask

    ////////////////////////////////////////
    // Stimulus

    // Starts and ends 1 ns after a rising edge
    task automatic send_packet(input int port, input int len);
        word_t data;
        keep_t keep;
        int    waited;
        for (int w = 0; w < len; w++) begin
            data = $urandom;
            keep = (w == len - 1) ? keep_t'($urandom_range(1, 15)) : '1;
            ing_tdata[port]  = data;
            ing_tkeep[port]  = keep;
            ing_tlast[port]  = (w == len - 1);
            ing_tvalid[port] = 1'b1;
            if (port_enable[port]) begin
                exp_q[port].push_back({data, keep, w == len - 1});
            end
            @(negedge phys_port_clk_ifc);
            if (!port_enable[port]) begin
                check_value($sformatf("port %0d ready while disabled", port),
                            64'(ing_tready[port]), 64'(1));
            end
            waited = 0;
            while (!ing_tready[port]) begin
                waited++;
                if (waited > WAIT_LIMIT) begin
                    stop_on_failure($sformatf("ingress port %0d never became ready", port));
                end
                @(negedge phys_port_clk_ifc);
            end
            @(posedge phys_port_clk_ifc);
            #1;
        end
        ing_tvalid[port] = 1'b0;
        ing_tlast[port]  = 1'b0;
        if (port_enable[port]) begin
            sent_pkts[port]++;
        end
    endtask

    task automatic send_stream(input int port, input int pkts);
        for (int k = 0; k < pkts; k++) begin
            send_packet(port, int'($urandom_range(1, 16)));
        end
    endtask

    task automatic send_burst(input int pkts);
        fork
            send_stream(0, pkts);
            send_stream(1, pkts);
            send_stream(2, pkts);
            send_stream(3, pkts);
        join
    endtask

    task automatic wait_drain();
        int  waited;
        bit  busy;
        waited = 0;
        busy   = 1'b1;
        while (busy) begin
            @(negedge phys_port_clk_ifc);
            busy = (egr_tvalid != '0);
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (exp_q[p].size() != 0) begin
                    busy = 1'b1;
                end
            end
            waited++;
            if (waited > WAIT_LIMIT) begin
                stop_on_failure("egress did not drain the expected packets");
            end
        end
        // Ingress count lands two edges after the stored tlast
        repeat (2) @(posedge phys_port_clk_ifc);
        #1;
    endtask

    task automatic check_counters();
        @(negedge phys_port_clk_ifc);
        for (int p = 0; p < NUM_PORTS; p++) begin
            check_value($sformatf("port %0d ingress count", p),
                        64'(ing_pkt_cnt[p]), 64'(sent_pkts[p]));
            check_value($sformatf("port %0d egress count", p),
                        64'(egr_pkt_cnt[p]), 64'(rx_pkts[p]));
        end
        @(posedge phys_port_clk_ifc);
        #1;
    endtask

    ////////////////////////////////////////
    // Egress side

    initial begin
        forever begin
            @(posedge phys_port_clk_ifc);
            #1;
            if (random_ready) begin
                egr_tready = NUM_PORTS'($urandom);
            end else begin
                egr_tready = '1;
            end
        end
    end

    // Transfers are seen at the negedge before their edge
    initial begin : egress_monitor
        logic [36:0] entry;
        forever begin
            @(negedge phys_port_clk_ifc);
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (egr_tvalid[p] && egr_tready[p] && !rst) begin
                    if (exp_q[p].size() == 0) begin
                        stop_on_failure($sformatf("unexpected word on egress port %0d", p));
                    end
                    entry = exp_q[p].pop_front();
                    check_value($sformatf("port %0d egress data", p),
                                64'(egr_tdata[p]), 64'(entry[36:5]));
                    check_value($sformatf("port %0d egress keep", p),
                                64'(egr_tkeep[p]), 64'(entry[4:1]));
                    check_value($sformatf("port %0d egress last", p),
                                64'(egr_tlast[p]), 64'(entry[0]));
                    if (entry[0]) begin
                        rx_pkts[p]++;
                    end
                end
            end
        end
    end

    ////////////////////////////////////////
    // Tests

    task automatic test_single_packet();
        send_packet(0, 6);
        wait_drain();
    endtask

    task automatic test_concurrent_ports();
        send_burst(3);
        wait_drain();
    endtask

    task automatic test_random_ready();
        random_ready = 1'b1;
        send_burst(4);
        wait_drain();
        random_ready = 1'b0;
    endtask

    task automatic test_disabled_port();
        port_enable[2] = 1'b0;
        send_burst(3);
        wait_drain();
        check_counters();
    endtask

    task automatic test_clear();
        check_counters();
        cnt_clear[1] = 1'b1;
        @(posedge phys_port_clk_ifc);
        #1;
        cnt_clear[1] = 1'b0;
        sent_pkts[1] = 0;
        rx_pkts[1]   = 0;
        check_counters();
    endtask

    initial begin : main
        void'($urandom(32'h7745));
        rst          = 1'b1;
        ing_tdata    = '0;
        ing_tkeep    = '0;
        ing_tlast    = '0;
        ing_tvalid   = '0;
        egr_tready   = '1;
        port_enable  = '1;
        cnt_clear    = '0;
        random_ready = 1'b0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            sent_pkts[p] = 0;
            rx_pkts[p]   = 0;
        end
        repeat (5) @(posedge phys_port_clk_ifc);
        #1;
        rst = 1'b0;
        @(negedge phys_port_clk_ifc);
        check_value("egress valid after reset", 64'(egr_tvalid), 64'(0));
        check_value("ingress ready after reset", 64'(ing_tready), 64'(4'hf));
        check_counters();

        test_single_packet();
        test_concurrent_ports();
        test_random_ready();
        test_disabled_port();
        test_clear();

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
verilog/router_pkg.sv
verilog/port_fifo.sv
verilog/ingress_arbiter.sv
verilog/egress_demux.sv
verilog/packet_counters.sv
verilog/router_top.sv
bench/router_tb.sv

// ==== Makefile ====
# Verilator build and run of the router testbench

OBJ_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build and run router_tb with Verilator"
	@echo "  clean  remove the build output"

test:
	verilator --binary --timing -j 0 -f build.f --top-module router_tb -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/Vrouter_tb

clean:
	rm -rf $(OBJ_DIR)
